// File: filter_out_if.sv
`timescale 1ns/100ps
`default_nettype none

interface filter_out_if;

	logic empty;
	logic almost_full;
	logic rd_en;
	// Valid whenever empty is low
	md_filter_pkg::disp_t head;

	modport filter
	(
		output empty,
		output almost_full,
		output head,
		input  rd_en
	);

	modport collector
	(
		input  empty,
		input  almost_full,
		input  head,
		output rd_en
	);

endinterface

`default_nettype wire

// File: md_filter_bank.sv
`timescale 1ns/100ps
`default_nettype none

module md_filter_bank
(
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       in_valid,
	input  logic [md_filter_pkg::ID_WIDTH-1:0]         ref_id,
	input  logic [md_filter_pkg::ID_WIDTH-1:0]         nb_id,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        ref_x,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        ref_y,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        ref_z,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        nb_x,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        nb_y,
	input  logic [md_filter_pkg::POS_WIDTH-1:0]        nb_z,
	input  logic                                       drain_en,
	output logic                                       back_pressure,
	output logic                                       all_empty,
	output logic                                       out_valid,
	output logic [md_filter_pkg::ID_WIDTH-1:0]         out_ref_id,
	output logic [md_filter_pkg::ID_WIDTH-1:0]         out_nb_id,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dx,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dy,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dz,
	output logic [md_filter_pkg::R2_WIDTH-1:0]         out_r2
);

	md_filter_pkg::pair_t in_pair;
	md_filter_pkg::pair_t lane_pair;
	logic [md_filter_pkg::NUM_FILTER-1:0] lane_valid;
	logic [md_filter_pkg::NUM_FILTER-1:0] lane_almost_full;

	filter_out_if lane_if [md_filter_pkg::NUM_FILTER] ();

	// Field order of pair_t
	assign in_pair = {ref_id, nb_id, ref_x, ref_y, ref_z, nb_x, nb_y, nb_z};

	pair_dispatcher u_dispatcher
	(
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_pair       (in_pair),
		.almost_full   (lane_almost_full),
		.lane_valid    (lane_valid),
		.lane_pair     (lane_pair),
		.back_pressure (back_pressure)
	);

	genvar i;
	generate
		for (i = 0; i < md_filter_pkg::NUM_FILTER; i++)
		begin : g_filter
			range_filter u_filter
			(
				.clk      (clk),
				.rst      (rst),
				.in_valid (lane_valid[i]),
				.in_pair  (lane_pair),
				.out      (lane_if[i])
			);
			assign lane_almost_full[i] = lane_if[i].almost_full;
		end
	endgenerate

	pair_collector u_collector
	(
		.clk        (clk),
		.rst        (rst),
		.drain_en   (drain_en),
		.lanes      (lane_if),
		.all_empty  (all_empty),
		.out_valid  (out_valid),
		.out_ref_id (out_ref_id),
		.out_nb_id  (out_nb_id),
		.out_dx     (out_dx),
		.out_dy     (out_dy),
		.out_dz     (out_dz),
		.out_r2     (out_r2)
	);

endmodule

`default_nettype wire

// File: md_filter_bank_sva.sv
`timescale 1ns/100ps
`default_nettype none

module md_filter_bank_sva
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic back_pressure,
	input logic all_empty,
	input logic out_valid
);

	int fail_count = 0;

	a_no_input_under_bp: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> !back_pressure)
	else
	begin
		fail_count++;
		$error("in_valid high while back_pressure is high");
	end

	// Reset reaches out_valid one edge after rst is seen
	a_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
	else
	begin
		fail_count++;
		$error("out_valid high during reset");
	end

	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !out_valid ##1 !out_valid)
	else
	begin
		fail_count++;
		$error("out_valid high right after reset");
	end

	// At most three items sit in the collector pipeline
	a_empty_drains: assert property (@(posedge clk) disable iff (rst)
		(all_empty && out_valid) [*3] |=> !(all_empty && out_valid))
	else
	begin
		fail_count++;
		$error("out_valid stayed high with all lanes empty");
	end

endmodule

bind md_filter_bank md_filter_bank_sva u_sva (.*);

`default_nettype wire

// File: md_filter_pkg.sv
`default_nettype none

package md_filter_pkg;

	// Lane count and datapath widths
	localparam int NUM_FILTER = 8;
	localparam int LANE_WIDTH = $clog2(NUM_FILTER);
	localparam int POS_WIDTH = 16;
	localparam int ID_WIDTH = 16;
	localparam int R2_WIDTH = 32;

	// Half-width of the cutoff cube
	localparam int CUTOFF = 2048;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
	// Leaves room for the three pairs in flight ahead of a FIFO write
	localparam int ALMOST_FULL_LEVEL = FIFO_DEPTH - 4;

	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nb_id;
		logic [POS_WIDTH-1:0] ref_x;
		logic [POS_WIDTH-1:0] ref_y;
		logic [POS_WIDTH-1:0] ref_z;
		logic [POS_WIDTH-1:0] nb_x;
		logic [POS_WIDTH-1:0] nb_y;
		logic [POS_WIDTH-1:0] nb_z;
	} pair_t;

	// Displacements are neighbor minus reference
	typedef struct packed {
		logic [ID_WIDTH-1:0] ref_id;
		logic [ID_WIDTH-1:0] nb_id;
		logic signed [POS_WIDTH-1:0] dx;
		logic signed [POS_WIDTH-1:0] dy;
		logic signed [POS_WIDTH-1:0] dz;
	} disp_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_GRANT
	} arb_state_e;

endpackage

`default_nettype wire

// File: pair_collector.sv
`timescale 1ns/100ps
`default_nettype none

module pair_collector
(
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    drain_en,
	filter_out_if.collector                         lanes [md_filter_pkg::NUM_FILTER],
	output logic                                    all_empty,
	output logic                                    out_valid,
	output logic [md_filter_pkg::ID_WIDTH-1:0]      out_ref_id,
	output logic [md_filter_pkg::ID_WIDTH-1:0]      out_nb_id,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dx,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dy,
	output logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dz,
	output logic [md_filter_pkg::R2_WIDTH-1:0]      out_r2
);

	logic [md_filter_pkg::NUM_FILTER-1:0] lane_empty;
	md_filter_pkg::disp_t lane_head [md_filter_pkg::NUM_FILTER];
	logic [md_filter_pkg::NUM_FILTER-1:0] grant;
	logic [md_filter_pkg::LANE_WIDTH-1:0] last_grant;
	logic [md_filter_pkg::LANE_WIDTH-1:0] next_lane;
	logic [md_filter_pkg::LANE_WIDTH-1:0] cand;
	logic found;
	logic pop;
	// ARB_GRANT while the popped head sits in s1_disp
	md_filter_pkg::arb_state_e state;
	md_filter_pkg::disp_t s1_disp;
	logic signed [md_filter_pkg::R2_WIDTH-1:0] sq_x_c;
	logic signed [md_filter_pkg::R2_WIDTH-1:0] sq_y_c;
	logic signed [md_filter_pkg::R2_WIDTH-1:0] sq_z_c;
	logic s2_valid;
	md_filter_pkg::disp_t s2_disp;
	logic [md_filter_pkg::R2_WIDTH-1:0] s2_sq_x;
	logic [md_filter_pkg::R2_WIDTH-1:0] s2_sq_y;
	logic [md_filter_pkg::R2_WIDTH-1:0] s2_sq_z;

	genvar i;
	generate
		for (i = 0; i < md_filter_pkg::NUM_FILTER; i++)
		begin : g_lane
			assign lane_empty[i] = lanes[i].empty;
			assign lane_head[i] = lanes[i].head;
			assign lanes[i].rd_en = grant[i];
		end
	endgenerate

	assign all_empty = &lane_empty;

	// First non-empty lane after the last grant
	always_comb
	begin
		found = 1'b0;
		next_lane = last_grant;
		cand = last_grant;
		for (int k = 1; k <= md_filter_pkg::NUM_FILTER; k++)
		begin
			cand = last_grant + md_filter_pkg::LANE_WIDTH'(k);
			if (!found && !lane_empty[cand])
			begin
				found = 1'b1;
				next_lane = cand;
			end
		end
	end

	assign pop = drain_en && found;

	always_comb
	begin
		grant = '0;
		if (pop)
		begin
			grant[next_lane] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= md_filter_pkg::ARB_IDLE;
			// Lane 0 is served first
			last_grant <= '1;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			state <= pop ? md_filter_pkg::ARB_GRANT : md_filter_pkg::ARB_IDLE;
			if (pop)
			begin
				last_grant <= next_lane;
			end
			s2_valid <= (state == md_filter_pkg::ARB_GRANT);
			out_valid <= s2_valid;
		end
	end

	assign sq_x_c = s1_disp.dx * s1_disp.dx;
	assign sq_y_c = s1_disp.dy * s1_disp.dy;
	assign sq_z_c = s1_disp.dz * s1_disp.dz;

	// Head capture, squares, then sum
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			s1_disp <= lane_head[next_lane];
		end
		s2_disp <= s1_disp;
		s2_sq_x <= sq_x_c;
		s2_sq_y <= sq_y_c;
		s2_sq_z <= sq_z_c;
		out_ref_id <= s2_disp.ref_id;
		out_nb_id <= s2_disp.nb_id;
		out_dx <= s2_disp.dx;
		out_dy <= s2_disp.dy;
		out_dz <= s2_disp.dz;
		out_r2 <= s2_sq_x + s2_sq_y + s2_sq_z;
	end

endmodule

`default_nettype wire

// File: pair_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module pair_dispatcher
(
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  in_valid,
	input  md_filter_pkg::pair_t                  in_pair,
	input  logic [md_filter_pkg::NUM_FILTER-1:0]  almost_full,
	output logic [md_filter_pkg::NUM_FILTER-1:0]  lane_valid,
	output md_filter_pkg::pair_t                  lane_pair,
	output logic                                  back_pressure
);

	// One-hot pointer to the lane that gets the next pair
	logic [md_filter_pkg::NUM_FILTER-1:0] rot_ptr;
	logic accept;

	assign back_pressure = |almost_full;
	assign accept = in_valid && !back_pressure;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lane_valid <= '0;
			rot_ptr <= {{(md_filter_pkg::NUM_FILTER-1){1'b0}}, 1'b1};
		end
		else
		begin
			if (accept)
			begin
				lane_valid <= rot_ptr;
				rot_ptr <= {rot_ptr[md_filter_pkg::NUM_FILTER-2:0],
					rot_ptr[md_filter_pkg::NUM_FILTER-1]};
			end
			else
			begin
				lane_valid <= '0;
			end
		end
	end

	// Shared by all lanes, only the strobe selects
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lane_pair <= in_pair;
		end
	end

endmodule

`default_nettype wire

// File: pair_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pair_fifo
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr_en,
	input  md_filter_pkg::disp_t wr_data,
	input  logic                 rd_en,
	output md_filter_pkg::disp_t rd_data,
	output logic                 empty,
	output logic                 almost_full
);

	md_filter_pkg::disp_t mem [md_filter_pkg::FIFO_DEPTH];
	logic [md_filter_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [md_filter_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;
	logic [md_filter_pkg::FIFO_ADDR_WIDTH:0] count;
	logic full;
	logic do_write;
	logic do_read;

	assign full = (count == md_filter_pkg::FIFO_DEPTH);
	assign empty = (count == '0);
	assign almost_full = (count >= md_filter_pkg::ALMOST_FULL_LEVEL);
	assign do_write = wr_en && !full;
	assign do_read = rd_en && !empty;

	// Show-ahead head
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: range_filter.sv
`timescale 1ns/100ps
`default_nettype none

module range_filter
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  md_filter_pkg::pair_t in_pair,
	filter_out_if.filter         out
);

	logic s1_valid;
	md_filter_pkg::disp_t s1_disp;
	logic pass_x;
	logic pass_y;
	logic pass_z;
	logic wr_en;

	function automatic logic within_cutoff(input logic signed [md_filter_pkg::POS_WIDTH-1:0] d);
		logic [md_filter_pkg::POS_WIDTH-1:0] mag;
		mag = d[md_filter_pkg::POS_WIDTH-1] ? -d : d;
		return (mag <= md_filter_pkg::CUTOFF);
	endfunction

	// Stage 1, IDs and signed differences
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_disp.ref_id <= in_pair.ref_id;
			s1_disp.nb_id <= in_pair.nb_id;
			s1_disp.dx <= in_pair.nb_x - in_pair.ref_x;
			s1_disp.dy <= in_pair.nb_y - in_pair.ref_y;
			s1_disp.dz <= in_pair.nb_z - in_pair.ref_z;
		end
	end

	// Stage 2, cube test on all three axes
	assign pass_x = within_cutoff(s1_disp.dx);
	assign pass_y = within_cutoff(s1_disp.dy);
	assign pass_z = within_cutoff(s1_disp.dz);
	assign wr_en = s1_valid && pass_x && pass_y && pass_z;

	pair_fifo u_fifo
	(
		.clk         (clk),
		.rst         (rst),
		.wr_en       (wr_en),
		.wr_data     (s1_disp),
		.rd_en       (out.rd_en),
		.rd_data     (out.head),
		.empty       (out.empty),
		.almost_full (out.almost_full)
	);

endmodule

`default_nettype wire

// File: sources.f
md_filter_pkg.sv
filter_out_if.sv
pair_dispatcher.sv
pair_fifo.sv
range_filter.sv
pair_collector.sv
md_filter_bank.sv
tb_clock_gen.sv
tb_checker.sv
md_filter_bank_sva.sv
tb_md_filter_bank.sv

// File: tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker
(
	input logic                                    clk,
	input logic                                    rst,
	input logic                                    out_valid,
	input logic [md_filter_pkg::ID_WIDTH-1:0]      out_ref_id,
	input logic [md_filter_pkg::ID_WIDTH-1:0]      out_nb_id,
	input logic [md_filter_pkg::POS_WIDTH-1:0]     out_dx,
	input logic [md_filter_pkg::POS_WIDTH-1:0]     out_dy,
	input logic [md_filter_pkg::POS_WIDTH-1:0]     out_dz,
	input logic [md_filter_pkg::R2_WIDTH-1:0]      out_r2
);

	// Keyed by {ref_id, nb_id}, holds {dx, dy, dz, r2}
	logic [79:0] expected [logic [31:0]];
	logic [31:0] key;
	logic [79:0] want;
	int error_count = 0;
	int match_count = 0;

	task automatic add_expected(input logic [15:0] ref_id, input logic [15:0] nb_id,
		input logic [15:0] dx, input logic [15:0] dy, input logic [15:0] dz,
		input logic [31:0] r2);
		expected[{ref_id, nb_id}] = {dx, dy, dz, r2};
	endtask

	function automatic int pending();
		return expected.num();
	endfunction

	task automatic compare_field(input string name, input logic [31:0] pair_key,
		input logic [31:0] got, input logic [31:0] exp_value);
		if (got !== exp_value)
		begin
			error_count++;
			$display("Mismatch %s for pair ref %h nb %h: got %h expected %h",
				name, pair_key[31:16], pair_key[15:0], got, exp_value);
		end
	endtask

	task automatic report_missing();
		foreach (expected[k])
		begin
			error_count++;
			$display("Pair ref %h nb %h passed the cube test but never came out",
				k[31:16], k[15:0]);
		end
	endtask

	always @(posedge clk)
	begin
		if (!rst && out_valid)
		begin
			key = {out_ref_id, out_nb_id};
			if (!expected.exists(key))
			begin
				error_count++;
				$display("Unexpected pair ref %h nb %h came out (dropped, repeated or unknown)",
					out_ref_id, out_nb_id);
			end
			else
			begin
				want = expected[key];
				expected.delete(key);
				compare_field("out_dx", key, {16'd0, out_dx}, {16'd0, want[79:64]});
				compare_field("out_dy", key, {16'd0, out_dy}, {16'd0, want[63:48]});
				compare_field("out_dz", key, {16'd0, out_dz}, {16'd0, want[47:32]});
				compare_field("out_r2", key, out_r2, want[31:0]);
				match_count++;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 40
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: tb_md_filter_bank.sv
`timescale 1ns/100ps
`default_nettype none

module tb_md_filter_bank;

	// Paced sends let a pair land in its FIFO before back_pressure is read
	localparam int PACED_GAP = 4;
	localparam int BP_MAX_PAIRS = 120;
	localparam int TOTAL_PAIRS = 16 + 23 + 64 + BP_MAX_PAIRS + 24;
	localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * 20 + 2000;
	localparam int DRAIN_LIMIT = 400;

	typedef struct packed {
		logic pass;
		logic [15:0] dx;
		logic [15:0] dy;
		logic [15:0] dz;
		logic [31:0] r2;
	} ref_result_t;

	logic clk;
	logic rst;
	logic in_valid;
	logic [md_filter_pkg::ID_WIDTH-1:0] ref_id;
	logic [md_filter_pkg::ID_WIDTH-1:0] nb_id;
	logic [md_filter_pkg::POS_WIDTH-1:0] ref_x;
	logic [md_filter_pkg::POS_WIDTH-1:0] ref_y;
	logic [md_filter_pkg::POS_WIDTH-1:0] ref_z;
	logic [md_filter_pkg::POS_WIDTH-1:0] nb_x;
	logic [md_filter_pkg::POS_WIDTH-1:0] nb_y;
	logic [md_filter_pkg::POS_WIDTH-1:0] nb_z;
	logic drain_en;
	logic back_pressure;
	logic all_empty;
	logic out_valid;
	logic [md_filter_pkg::ID_WIDTH-1:0] out_ref_id;
	logic [md_filter_pkg::ID_WIDTH-1:0] out_nb_id;
	logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dx;
	logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dy;
	logic signed [md_filter_pkg::POS_WIDTH-1:0] out_dz;
	logic [md_filter_pkg::R2_WIDTH-1:0] out_r2;

	logic [31:0] rng_state;
	int next_id;
	int sent_count;
	int tb_errors;

	tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

	md_filter_bank u_dut
	(
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.ref_id        (ref_id),
		.nb_id         (nb_id),
		.ref_x         (ref_x),
		.ref_y         (ref_y),
		.ref_z         (ref_z),
		.nb_x          (nb_x),
		.nb_y          (nb_y),
		.nb_z          (nb_z),
		.drain_en      (drain_en),
		.back_pressure (back_pressure),
		.all_empty     (all_empty),
		.out_valid     (out_valid),
		.out_ref_id    (out_ref_id),
		.out_nb_id     (out_nb_id),
		.out_dx        (out_dx),
		.out_dy        (out_dy),
		.out_dz        (out_dz),
		.out_r2        (out_r2)
	);

	tb_checker u_checker
	(
		.clk        (clk),
		.rst        (rst),
		.out_valid  (out_valid),
		.out_ref_id (out_ref_id),
		.out_nb_id  (out_nb_id),
		.out_dx     (out_dx),
		.out_dy     (out_dy),
		.out_dz     (out_dz),
		.out_r2     (out_r2)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_offset(input int max_d);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % (2 * max_d + 1)) - max_d;
	endfunction

	// Reference kept far enough from the edges that neighbor stays in 15 bits
	function automatic md_filter_pkg::pair_t make_pair(input int dx, input int dy, input int dz);
		md_filter_pkg::pair_t p;
		rng_state = xorshift32(rng_state);
		p.ref_x = 16'(4096 + rng_state[14:0] % 24576);
		p.nb_id = rng_state[31:16];
		rng_state = xorshift32(rng_state);
		p.ref_y = 16'(4096 + rng_state[14:0] % 24576);
		rng_state = xorshift32(rng_state);
		p.ref_z = 16'(4096 + rng_state[14:0] % 24576);
		p.nb_x = 16'(int'(p.ref_x) + dx);
		p.nb_y = 16'(int'(p.ref_y) + dy);
		p.nb_z = 16'(int'(p.ref_z) + dz);
		p.ref_id = 16'(next_id);
		next_id++;
		return p;
	endfunction

	// Cube test and squared distance, neighbor minus reference
	function automatic ref_result_t reference_result(input md_filter_pkg::pair_t p);
		ref_result_t res;
		int dx;
		int dy;
		int dz;
		dx = int'(p.nb_x) - int'(p.ref_x);
		dy = int'(p.nb_y) - int'(p.ref_y);
		dz = int'(p.nb_z) - int'(p.ref_z);
		res.pass = (dx >= -md_filter_pkg::CUTOFF) && (dx <= md_filter_pkg::CUTOFF) &&
			(dy >= -md_filter_pkg::CUTOFF) && (dy <= md_filter_pkg::CUTOFF) &&
			(dz >= -md_filter_pkg::CUTOFF) && (dz <= md_filter_pkg::CUTOFF);
		res.dx = dx[15:0];
		res.dy = dy[15:0];
		res.dz = dz[15:0];
		res.r2 = 32'(dx * dx + dy * dy + dz * dz);
		return res;
	endfunction

	function automatic int error_total();
		return tb_errors + u_checker.error_count + u_dut.u_sva.fail_count;
	endfunction

	task automatic send_pair(input md_filter_pkg::pair_t p, input int gap);
		ref_result_t res;
		@(posedge clk);
		while (back_pressure)
		begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		in_valid <= 1'b1;
		ref_id <= p.ref_id;
		nb_id <= p.nb_id;
		ref_x <= p.ref_x;
		ref_y <= p.ref_y;
		ref_z <= p.ref_z;
		nb_x <= p.nb_x;
		nb_y <= p.nb_y;
		nb_z <= p.nb_z;
		res = reference_result(p);
		if (res.pass)
		begin
			u_checker.add_expected(p.ref_id, p.nb_id, res.dx, res.dy, res.dz, res.r2);
		end
		sent_count++;
		repeat (gap)
		begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		int cycles;
		@(posedge clk);
		in_valid <= 1'b0;
		cycles = 0;
		while (u_checker.pending() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		repeat (8) @(posedge clk);
		$display("Test %0d (%s) finished, %0d errors so far", num, name, error_total());
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, traffic did not finish", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	initial
	begin
		int n;
		rst = 1'b1;
		in_valid = 1'b0;
		ref_id = '0;
		nb_id = '0;
		ref_x = '0;
		ref_y = '0;
		ref_z = '0;
		nb_x = '0;
		nb_y = '0;
		nb_z = '0;
		drain_en = 1'b1;
		rng_state = 32'h958;
		next_id = 0;
		sent_count = 0;
		tb_errors = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		if (!all_empty || back_pressure || out_valid)
		begin
			tb_errors++;
			$display("Outputs not idle after reset");
		end

		for (int i = 0; i < 16; i++)
		begin
			send_pair(make_pair(rand_offset(1024), rand_offset(1024), rand_offset(1024)), 1);
		end
		finish_test(1, "near pairs");

		// Exactly CUTOFF passes, one more is dropped
		send_pair(make_pair(2048, 0, 0), 0);
		send_pair(make_pair(-2048, 5, -5), 0);
		send_pair(make_pair(0, 2048, -2048), 0);
		send_pair(make_pair(2049, 0, 0), 0);
		send_pair(make_pair(0, -2049, 0), 0);
		send_pair(make_pair(0, 0, 2049), 0);
		send_pair(make_pair(-2049, 2049, -2049), 0);
		for (int i = 0; i < 16; i++)
		begin
			send_pair(make_pair(rand_offset(4096), rand_offset(4096), rand_offset(4096)), 0);
		end
		finish_test(2, "cube boundary");

		for (int i = 0; i < 64; i++)
		begin
			send_pair(make_pair(rand_offset(3000), rand_offset(3000), rand_offset(3000)), 0);
		end
		finish_test(3, "burst");

		@(posedge clk);
		drain_en <= 1'b0;
		n = 0;
		while (!back_pressure && n < BP_MAX_PAIRS)
		begin
			send_pair(make_pair(rand_offset(1000), rand_offset(1000), rand_offset(1000)),
				PACED_GAP);
			n++;
		end
		if (!back_pressure)
		begin
			tb_errors++;
			$display("back_pressure never rose with drain_en low after %0d pairs", n);
		end
		repeat (8)
		begin
			@(posedge clk);
			if (!back_pressure)
			begin
				tb_errors++;
				$display("back_pressure fell while drain_en was still low");
			end
		end
		drain_en <= 1'b1;
		for (int i = 0; i < 24; i++)
		begin
			send_pair(make_pair(rand_offset(1000), rand_offset(1000), rand_offset(1000)),
				PACED_GAP);
		end
		finish_test(4, "back-pressure");

		repeat (20)
		begin
			@(posedge clk);
			if (out_valid || !all_empty)
			begin
				tb_errors++;
				$display("Bank not idle after draining: out_valid %b all_empty %b",
					out_valid, all_empty);
			end
		end
		$display("Test 5 (idle after drain) finished, %0d errors so far", error_total());

		u_checker.report_missing();
		$display("Summary: %0d pairs sent, %0d outputs matched, %0d errors",
			sent_count, u_checker.match_count, error_total());
		if (error_total() == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
